// File: design/cpuPkg.sv
package cpuPkg;

  localparam int xlen = 32;
  localparam int regIndexWidth = 5;
  localparam int imemDepth = 64;
  localparam int dmemDepth = 64;
  localparam int imemAddrWidth = $clog2(imemDepth);
  localparam int dmemAddrWidth = $clog2(dmemDepth);

  // RV32I major opcodes
  localparam logic [6:0] opRType = 7'b0110011;
  localparam logic [6:0] opIType = 7'b0010011;
  localparam logic [6:0] opLoad = 7'b0000011;
  localparam logic [6:0] opStore = 7'b0100011;

  // Main control class handed to ALU control
  typedef enum logic [1:0] {
    aluOpAdd = 2'b00,
    aluOpRegister = 2'b10,
    aluOpImmediate = 2'b11
  } aluOpType;

  typedef enum logic [2:0] {
    aluAdd = 3'd0,
    aluSub = 3'd1,
    aluAnd = 3'd2,
    aluOr = 3'd3,
    aluSlt = 3'd4
  } aluControlType;

  // Same encoding as the reference select lines
  typedef enum logic [1:0] {
    fromRegister = 2'b00,
    fromWriteBack = 2'b01,
    fromMemory = 2'b10
  } forwardType;

  typedef struct packed {
    logic valid;
    logic [xlen-1:0] instruction;
  } ifIdType;

  typedef struct packed {
    logic [xlen-1:0] lhsValue;
    logic [xlen-1:0] rhsValue;
    logic [regIndexWidth-1:0] lhsIndex;
    logic [regIndexWidth-1:0] rhsIndex;
    logic [regIndexWidth-1:0] writeRegisterIndex;
    logic [xlen-1:0] immediate;
    logic [2:0] funct3;
    logic [6:0] funct7;
    aluOpType aluOp;
    logic aluSrc;
    logic memWrite;
    logic memRead;
    logic memToReg;
    logic regWrite;
  } idExType;

  typedef struct packed {
    logic [xlen-1:0] aluResult;
    logic [xlen-1:0] memoryWriteData;
    logic [regIndexWidth-1:0] writeRegisterIndex;
    logic memWrite;
    logic memRead;
    logic memToReg;
    logic regWrite;
  } exMemType;

  typedef struct packed {
    logic [xlen-1:0] memoryData;
    logic [xlen-1:0] executionData;
    logic [regIndexWidth-1:0] writeRegisterIndex;
    logic memToReg;
    logic regWrite;
  } memWbType;

  typedef struct packed {
    logic valid;
    logic [regIndexWidth-1:0] writeRegisterIndex;
    logic [xlen-1:0] data;
  } retireType;

  typedef struct packed {
    logic valid;
    logic [imemAddrWidth-1:0] address;
    logic [xlen-1:0] instruction;
  } loadType;

endpackage

// File: design/InstructionFetch.sv
`timescale 1ns/1ps

module InstructionFetch (
  input  logic clk,
  input  logic reset,
  input  cpuPkg::loadType load,
  output logic loadReady,
  output cpuPkg::ifIdType fetched
);

  logic [cpuPkg::xlen-1:0] instructionMemory [cpuPkg::imemDepth];
  logic [cpuPkg::imemAddrWidth-1:0] pc;

  // Loading is only open while the core is held in reset
  assign loadReady = reset;

  always_ff @(posedge clk) begin
    if (load.valid && loadReady) begin
      instructionMemory[load.address] <= load.instruction;
    end
  end

  // Output register doubles as the IF/ID barrier
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
      fetched <= '0;
    end else begin
      // Word counter, wraps at the end of memory
      pc <= pc + 1'b1;
      fetched.valid <= 1'b1;
      fetched.instruction <= instructionMemory[pc];
    end
  end

endmodule

// File: design/RegisterFile.sv
`timescale 1ns/1ps

module RegisterFile (
  input  logic clk,
  input  logic [cpuPkg::regIndexWidth-1:0] source1RegisterIndex,
  input  logic [cpuPkg::regIndexWidth-1:0] source2RegisterIndex,
  input  logic [cpuPkg::regIndexWidth-1:0] writeRegisterIndex,
  input  logic [cpuPkg::xlen-1:0] writeRegisterData,
  input  logic shouldWrite,
  output logic [cpuPkg::xlen-1:0] source1RegisterData,
  output logic [cpuPkg::xlen-1:0] source2RegisterData
);

  localparam int registerCount = 1 << cpuPkg::regIndexWidth;

  // No storage behind x0
  logic [cpuPkg::xlen-1:0] registers [1:registerCount-1];

  always_ff @(posedge clk) begin
    if (shouldWrite && writeRegisterIndex != '0) begin
      registers[writeRegisterIndex] <= writeRegisterData;
    end
  end

  function automatic logic [cpuPkg::xlen-1:0] readPort(
    input logic [cpuPkg::regIndexWidth-1:0] index
  );
    if (index == '0) begin
      return '0;
    end
    // Write-through closes the WB to ID hazard
    if (shouldWrite && index == writeRegisterIndex) begin
      return writeRegisterData;
    end
    return registers[index];
  endfunction

  always_comb begin
    source1RegisterData = readPort(source1RegisterIndex);
    source2RegisterData = readPort(source2RegisterIndex);
  end

endmodule

// File: design/Decode.sv
`timescale 1ns/1ps

module Decode (
  input  cpuPkg::ifIdType fetched,
  input  logic [cpuPkg::xlen-1:0] lhsValue,
  input  logic [cpuPkg::xlen-1:0] rhsValue,
  output cpuPkg::idExType decoded
);

  logic [cpuPkg::xlen-1:0] instruction;
  logic [6:0] opcode;
  logic [cpuPkg::xlen-1:0] immediateI;
  logic [cpuPkg::xlen-1:0] immediateS;

  assign instruction = fetched.instruction;
  assign opcode = instruction[6:0];

  // Sign-extended immediates for both formats
  assign immediateI = {{20{instruction[31]}}, instruction[31:20]};
  assign immediateS = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};

  always_comb begin
    decoded = '0;
    decoded.lhsValue = lhsValue;
    decoded.rhsValue = rhsValue;
    decoded.lhsIndex = instruction[19:15];
    decoded.rhsIndex = instruction[24:20];
    decoded.writeRegisterIndex = instruction[11:7];
    decoded.funct3 = instruction[14:12];
    decoded.funct7 = instruction[31:25];
    decoded.immediate = (opcode == cpuPkg::opStore) ? immediateS : immediateI;
    decoded.aluOp = cpuPkg::aluOpAdd;

    // Bubbles and unknown opcodes keep every control bit low
    if (fetched.valid) begin
      case (opcode)
        cpuPkg::opRType: begin
          decoded.aluOp = cpuPkg::aluOpRegister;
          decoded.regWrite = 1'b1;
        end
        cpuPkg::opIType: begin
          decoded.aluOp = cpuPkg::aluOpImmediate;
          decoded.aluSrc = 1'b1;
          decoded.regWrite = 1'b1;
        end
        cpuPkg::opLoad: begin
          decoded.aluSrc = 1'b1;
          decoded.memRead = 1'b1;
          decoded.memToReg = 1'b1;
          decoded.regWrite = 1'b1;
        end
        cpuPkg::opStore: begin
          decoded.aluSrc = 1'b1;
          decoded.memWrite = 1'b1;
        end
        default: begin
          decoded.regWrite = 1'b0;
        end
      endcase
    end
  end

endmodule

// File: design/PipelineBarrier.sv
`timescale 1ns/1ps

module PipelineBarrier #(
  parameter type payloadType = logic
) (
  input  logic clk,
  input  logic reset,
  input  payloadType stageIn,
  output payloadType stageOut
);

  // All-zero payload is a bubble
  always_ff @(posedge clk) begin
    if (reset) begin
      stageOut <= '0;
    end else begin
      stageOut <= stageIn;
    end
  end

endmodule

// File: design/ForwardingUnit.sv
`timescale 1ns/1ps

module ForwardingUnit (
  input  logic [cpuPkg::regIndexWidth-1:0] executeStageReadRegisterIndex,
  input  logic [cpuPkg::regIndexWidth-1:0] memoryStageWriteRegisterIndex,
  input  logic isMemoryStageWrite,
  input  logic [cpuPkg::regIndexWidth-1:0] writebackStageWriteRegisterIndex,
  input  logic isWritebackStageWrite,
  output cpuPkg::forwardType forwardSelect
);

  // Youngest result wins, x0 never forwards
  always_comb begin
    if (isMemoryStageWrite && memoryStageWriteRegisterIndex != '0 &&
        memoryStageWriteRegisterIndex == executeStageReadRegisterIndex) begin
      forwardSelect = cpuPkg::fromMemory;
    end else if (isWritebackStageWrite && writebackStageWriteRegisterIndex != '0 &&
                 writebackStageWriteRegisterIndex == executeStageReadRegisterIndex) begin
      forwardSelect = cpuPkg::fromWriteBack;
    end else begin
      forwardSelect = cpuPkg::fromRegister;
    end
  end

endmodule

// File: design/Execute.sv
`timescale 1ns/1ps

module Execute (
  input  cpuPkg::idExType issued,
  input  cpuPkg::exMemType memStage,
  input  cpuPkg::retireType writeBackData,
  output cpuPkg::exMemType executed
);

  cpuPkg::forwardType lhsAluInputSelect;
  cpuPkg::forwardType rhsAluInputSelect;
  cpuPkg::aluControlType aluControl;
  logic [cpuPkg::xlen-1:0] lhsOperand;
  logic [cpuPkg::xlen-1:0] rhsForwarded;
  logic [cpuPkg::xlen-1:0] rhsOperand;
  logic [cpuPkg::xlen-1:0] aluResult;

  ForwardingUnit lhsForwardingUnit (
    .executeStageReadRegisterIndex(issued.lhsIndex),
    .memoryStageWriteRegisterIndex(memStage.writeRegisterIndex),
    .isMemoryStageWrite(memStage.regWrite),
    .writebackStageWriteRegisterIndex(writeBackData.writeRegisterIndex),
    .isWritebackStageWrite(writeBackData.valid),
    .forwardSelect(lhsAluInputSelect)
  );

  ForwardingUnit rhsForwardingUnit (
    .executeStageReadRegisterIndex(issued.rhsIndex),
    .memoryStageWriteRegisterIndex(memStage.writeRegisterIndex),
    .isMemoryStageWrite(memStage.regWrite),
    .writebackStageWriteRegisterIndex(writeBackData.writeRegisterIndex),
    .isWritebackStageWrite(writeBackData.valid),
    .forwardSelect(rhsAluInputSelect)
  );

  function automatic logic [cpuPkg::xlen-1:0] forwardMux(
    input cpuPkg::forwardType select,
    input logic [cpuPkg::xlen-1:0] registerValue,
    input logic [cpuPkg::xlen-1:0] memoryValue,
    input logic [cpuPkg::xlen-1:0] writeBackValue
  );
    case (select)
      cpuPkg::fromMemory: return memoryValue;
      cpuPkg::fromWriteBack: return writeBackValue;
      default: return registerValue;
    endcase
  endfunction

  always_comb begin
    lhsOperand = forwardMux(lhsAluInputSelect, issued.lhsValue,
                            memStage.aluResult, writeBackData.data);
    rhsForwarded = forwardMux(rhsAluInputSelect, issued.rhsValue,
                              memStage.aluResult, writeBackData.data);
    // Immediate replaces the operand after forwarding, store data stays forwarded
    rhsOperand = issued.aluSrc ? issued.immediate : rhsForwarded;
  end

  // ALU control
  always_comb begin
    aluControl = cpuPkg::aluAdd;
    if (issued.aluOp != cpuPkg::aluOpAdd) begin
      case (issued.funct3)
        3'b000: begin
          // funct7 only means sub for register-register ops
          if (issued.aluOp == cpuPkg::aluOpRegister && issued.funct7[5]) begin
            aluControl = cpuPkg::aluSub;
          end
        end
        3'b010: aluControl = cpuPkg::aluSlt;
        3'b110: aluControl = cpuPkg::aluOr;
        3'b111: aluControl = cpuPkg::aluAnd;
        default: aluControl = cpuPkg::aluAdd;
      endcase
    end
  end

  always_comb begin
    case (aluControl)
      cpuPkg::aluSub: aluResult = lhsOperand - rhsOperand;
      cpuPkg::aluAnd: aluResult = lhsOperand & rhsOperand;
      cpuPkg::aluOr: aluResult = lhsOperand | rhsOperand;
      cpuPkg::aluSlt: begin
        aluResult = {{(cpuPkg::xlen-1){1'b0}}, $signed(lhsOperand) < $signed(rhsOperand)};
      end
      default: aluResult = lhsOperand + rhsOperand;
    endcase
  end

  always_comb begin
    executed.aluResult = aluResult;
    executed.memoryWriteData = rhsForwarded;
    executed.writeRegisterIndex = issued.writeRegisterIndex;
    executed.memWrite = issued.memWrite;
    executed.memRead = issued.memRead;
    executed.memToReg = issued.memToReg;
    executed.regWrite = issued.regWrite;
  end

endmodule

// File: design/DataMemory.sv
`timescale 1ns/1ps

module DataMemory (
  input  logic clk,
  input  logic memWrite,
  input  logic [cpuPkg::xlen-1:0] address,
  input  logic [cpuPkg::xlen-1:0] writeData,
  output logic [cpuPkg::xlen-1:0] readData
);

  logic [cpuPkg::xlen-1:0] memory [cpuPkg::dmemDepth];
  logic [cpuPkg::dmemAddrWidth-1:0] wordIndex;

  // Drop the byte offset, upper bits wrap
  assign wordIndex = address[cpuPkg::dmemAddrWidth+1:2];

  always_ff @(posedge clk) begin
    if (memWrite) begin
      memory[wordIndex] <= writeData;
    end
  end

  assign readData = memory[wordIndex];

endmodule

// File: design/CPU.sv
`timescale 1ns/1ps

module CPU (
  input  logic clk,
  input  logic reset,
  input  cpuPkg::loadType load,
  output logic loadReady,
  output cpuPkg::retireType retire
);

  cpuPkg::ifIdType fetched;
  cpuPkg::idExType decoded;
  cpuPkg::idExType issued;
  cpuPkg::exMemType executed;
  cpuPkg::exMemType memStage;
  cpuPkg::memWbType memStageResult;
  cpuPkg::memWbType wbStage;

  logic [cpuPkg::xlen-1:0] idLHSRegisterValue;
  logic [cpuPkg::xlen-1:0] idRHSRegisterValue;
  logic [cpuPkg::xlen-1:0] memMemoryData;
  logic [cpuPkg::xlen-1:0] writeBackData;

  InstructionFetch instructionFetch (
    .clk(clk),
    .reset(reset),
    .load(load),
    .loadReady(loadReady),
    .fetched(fetched)
  );

  RegisterFile registerFile (
    .clk(clk),
    .source1RegisterIndex(fetched.instruction[19:15]),
    .source2RegisterIndex(fetched.instruction[24:20]),
    .writeRegisterIndex(wbStage.writeRegisterIndex),
    .writeRegisterData(writeBackData),
    .shouldWrite(wbStage.regWrite),
    .source1RegisterData(idLHSRegisterValue),
    .source2RegisterData(idRHSRegisterValue)
  );

  Decode decode (
    .fetched(fetched),
    .lhsValue(idLHSRegisterValue),
    .rhsValue(idRHSRegisterValue),
    .decoded(decoded)
  );

  PipelineBarrier #(.payloadType(cpuPkg::idExType)) idExBarrier (
    .clk(clk),
    .reset(reset),
    .stageIn(decoded),
    .stageOut(issued)
  );

  Execute execute (
    .issued(issued),
    .memStage(memStage),
    .writeBackData(retire),
    .executed(executed)
  );

  PipelineBarrier #(.payloadType(cpuPkg::exMemType)) exMemBarrier (
    .clk(clk),
    .reset(reset),
    .stageIn(executed),
    .stageOut(memStage)
  );

  DataMemory dataMemory (
    .clk(clk),
    .memWrite(memStage.memWrite),
    .address(memStage.aluResult),
    .writeData(memStage.memoryWriteData),
    .readData(memMemoryData)
  );

  // Only loads carry memory data onward
  always_comb begin
    memStageResult.memoryData = memStage.memRead ? memMemoryData : '0;
    memStageResult.executionData = memStage.aluResult;
    memStageResult.writeRegisterIndex = memStage.writeRegisterIndex;
    memStageResult.memToReg = memStage.memToReg;
    memStageResult.regWrite = memStage.regWrite;
  end

  PipelineBarrier #(.payloadType(cpuPkg::memWbType)) memWbBarrier (
    .clk(clk),
    .reset(reset),
    .stageIn(memStageResult),
    .stageOut(wbStage)
  );

  // Write-back mux
  assign writeBackData = wbStage.memToReg ? wbStage.memoryData : wbStage.executionData;

  always_comb begin
    retire.valid = wbStage.regWrite && (wbStage.writeRegisterIndex != '0);
    retire.writeRegisterIndex = wbStage.writeRegisterIndex;
    retire.data = writeBackData;
  end

endmodule

// File: testbench/CPUTbProgram.svh
// Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
logic [15:0] lfsrState = 16'd43;

logic [31:0] programWords [cpuPkg::imemDepth];
logic expectedWrite [cpuPkg::imemDepth];
logic [4:0] expectedIndex [cpuPkg::imemDepth];
logic [31:0] expectedData [cpuPkg::imemDepth];
logic [31:0] modelRegisters [32];
logic [31:0] modelMemory [cpuPkg::dmemDepth];
int programLength = 0;

function automatic logic nextLfsrBit();
  logic feedback;
  feedback = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
  lfsrState = {lfsrState[14:0], feedback};
  return feedback;
endfunction

function automatic logic [31:0] randomBits(input int count);
  logic [31:0] value;
  value = '0;
  for (int i = 0; i < count; i++) begin
    value = {value[30:0], nextLfsrBit()};
  end
  return value;
endfunction

task automatic resetModel();
  for (int i = 0; i < cpuPkg::imemDepth; i++) begin
    programWords[i] = '0;
    expectedWrite[i] = 1'b0;
  end
  // x0 is never written by the model
  modelRegisters[0] = '0;
  programLength = 0;
endtask

// Places one word and records what it should retire
task automatic appendWord(input logic [31:0] word, input logic writes, input int rd,
                          input logic [31:0] data);
  programWords[programLength] = word;
  expectedWrite[programLength] = writes && rd != 0;
  expectedIndex[programLength] = rd[4:0];
  expectedData[programLength] = data;
  if (writes && rd != 0) begin
    modelRegisters[rd] = data;
  end
  programLength++;
endtask

// funct3: 000 add or sub, 010 slt, 110 or, 111 and
task automatic registerOp(input logic [2:0] funct3, input logic isSub,
                          input int rd, input int rs1, input int rs2);
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] result;
  a = modelRegisters[rs1];
  b = modelRegisters[rs2];
  case (funct3)
    3'b010: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'b110: result = a | b;
    3'b111: result = a & b;
    default: result = isSub ? a - b : a + b;
  endcase
  appendWord({isSub ? 7'h20 : 7'h00, rs2[4:0], rs1[4:0], funct3, rd[4:0], 7'b0110011},
             1'b1, rd, result);
endtask

task automatic addImmediate(input int rd, input int rs1, input logic [31:0] imm);
  logic [31:0] result;
  result = modelRegisters[rs1] + {{20{imm[11]}}, imm[11:0]};
  appendWord({imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011}, 1'b1, rd, result);
endtask

task automatic loadWord(input int rd, input int rs1, input logic [31:0] imm);
  logic [31:0] address;
  address = modelRegisters[rs1] + {{20{imm[11]}}, imm[11:0]};
  appendWord({imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011}, 1'b1, rd,
             modelMemory[(address >> 2) % cpuPkg::dmemDepth]);
endtask

task automatic storeWord(input int rs2, input int rs1, input logic [31:0] imm);
  logic [31:0] address;
  address = modelRegisters[rs1] + {{20{imm[11]}}, imm[11:0]};
  modelMemory[(address >> 2) % cpuPkg::dmemDepth] = modelRegisters[rs2];
  appendWord({imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011}, 1'b0, 0, '0);
endtask

task automatic insertBubble();
  appendWord('0, 1'b0, 0, '0);
endtask

// File: testbench/CPUTb.sv
`timescale 1ns/1ps

module CPUTb;

  logic clk;
  logic reset;
  cpuPkg::loadType load;
  logic loadReady;
  cpuPkg::retireType retire;

  int cycle = 0;
  int resetEdges = 0;
  int failCount = 0;
  int testsPassed = 0;
  int testsFailed = 0;
  int retireTimeout = 200;
  int arithmeticLast;
  int forwardingLast;
  int memoryLast;
  int zeroRegisterLast;
  int timingLast;
  logic timedOut;
  logic inWindow;

  `include "CPUTbProgram.svh"

  CPU dut_i (
    .clk(clk),
    .reset(reset),
    .load(load),
    .loadReady(loadReady),
    .retire(retire)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Word n retires when the count since reset reaches n + 4
  always @(posedge clk) begin
    if (reset) begin
      cycle <= 0;
      resetEdges <= resetEdges + 1;
    end else begin
      cycle <= cycle + 1;
    end
  end

  assign inWindow = !reset && cycle >= 4 && cycle < cpuPkg::imemDepth + 4;

  resetRetireCheck: assert property (@(posedge clk) reset && resetEdges > 0 |-> !retire.valid)
    else begin
      failCount++;
      $display("FAILED retire.valid in reset expected 0 got %h", $sampled(retire.valid));
    end

  loadReadyCheck: assert property (@(posedge clk) loadReady == reset)
    else begin
      failCount++;
      $display("FAILED loadReady expected %h got %h", $sampled(reset), $sampled(loadReady));
    end

  retireValidCheck: assert property (@(posedge clk)
    inWindow |-> retire.valid == expectedWrite[cycle - 4])
    else begin
      failCount++;
      $display("FAILED retire.valid word %0d expected %h got %h", $sampled(cycle) - 4,
               expectedWrite[$sampled(cycle) - 4], $sampled(retire.valid));
    end

  retireIndexCheck: assert property (@(posedge clk)
    inWindow && expectedWrite[cycle - 4] |-> retire.writeRegisterIndex == expectedIndex[cycle - 4])
    else begin
      failCount++;
      $display("FAILED retire.writeRegisterIndex word %0d expected %h got %h",
               $sampled(cycle) - 4, expectedIndex[$sampled(cycle) - 4],
               $sampled(retire.writeRegisterIndex));
    end

  retireDataCheck: assert property (@(posedge clk)
    inWindow && expectedWrite[cycle - 4] |-> retire.data == expectedData[cycle - 4])
    else begin
      failCount++;
      $display("FAILED retire.data word %0d expected %h got %h", $sampled(cycle) - 4,
               expectedData[$sampled(cycle) - 4], $sampled(retire.data));
    end

  task automatic buildProgram();
    resetModel();
    for (int r = 1; r <= 6; r++) begin
      addImmediate(r, 0, randomBits(12));
    end
    registerOp(3'b000, 1'b0, 7, 1, 2);
    registerOp(3'b000, 1'b1, 8, 3, 4);
    registerOp(3'b111, 1'b0, 9, 5, 6);
    registerOp(3'b110, 1'b0, 10, 1, 3);
    registerOp(3'b010, 1'b0, 11, 2, 5);
    registerOp(3'b010, 1'b0, 12, 5, 2);
    arithmeticLast = programLength - 1;
    // Distances 1, 2 and 3 and then both stages holding x20
    addImmediate(13, 1, randomBits(12));
    registerOp(3'b000, 1'b0, 14, 13, 13);
    addImmediate(15, 2, randomBits(12));
    insertBubble();
    registerOp(3'b000, 1'b1, 16, 15, 1);
    addImmediate(17, 3, randomBits(12));
    insertBubble();
    insertBubble();
    registerOp(3'b110, 1'b0, 18, 17, 17);
    registerOp(3'b000, 1'b0, 19, 1, 18);
    addImmediate(20, 0, randomBits(12));
    addImmediate(20, 20, randomBits(12));
    registerOp(3'b000, 1'b0, 21, 20, 0);
    forwardingLast = programLength - 1;
    addImmediate(22, 0, randomBits(12));
    storeWord(22, 0, 4);
    addImmediate(23, 0, randomBits(12));
    storeWord(23, 0, 12);
    addImmediate(24, 0, randomBits(12));
    storeWord(24, 0, 40);
    loadWord(25, 0, 4);
    loadWord(26, 0, 12);
    loadWord(27, 0, 40);
    insertBubble();
    registerOp(3'b000, 1'b0, 28, 27, 26);
    memoryLast = programLength - 1;
    addImmediate(0, 1, randomBits(12));
    registerOp(3'b000, 1'b0, 0, 2, 3);
    registerOp(3'b000, 1'b0, 29, 0, 4);
    registerOp(3'b010, 1'b0, 30, 0, 1);
    zeroRegisterLast = programLength - 1;
    insertBubble();
    insertBubble();
    addImmediate(31, 0, randomBits(12));
    timingLast = programLength - 1;
  endtask

  // Reset stays high until every memory word is written
  task automatic loadProgram();
    for (int i = 0; i < cpuPkg::imemDepth; i++) begin
      @(negedge clk);
      load.valid = 1'b1;
      load.address = i[cpuPkg::imemAddrWidth-1:0];
      load.instruction = programWords[i];
    end
    @(negedge clk);
    load = '0;
    reset = 1'b0;
  endtask

  task automatic waitForRetire(input int index);
    int waited;
    waited = 0;
    while (!(retire.valid && cycle - 4 == index) && waited < retireTimeout) begin
      @(negedge clk);
      waited++;
    end
    if (!(retire.valid && cycle - 4 == index)) begin
      timedOut = 1'b1;
      $display("Timed out waiting for program word %0d to retire", index);
    end
  endtask

  task automatic reportTest(input string name, input int errorsBefore);
    if (failCount == errorsBefore && !timedOut) begin
      testsPassed++;
      $display("PASS  %s", name);
    end else begin
      testsFailed++;
      $display("FAIL  %s", name);
    end
  endtask

  task automatic runTest(input string name, input int lastIndex);
    int errorsBefore;
    errorsBefore = failCount;
    if (!timedOut) begin
      waitForRetire(lastIndex);
      // Last retire is checked on the next rising edge
      if (!timedOut) begin
        @(negedge clk);
      end
    end
    reportTest(name, errorsBefore);
  endtask

  initial begin
    reset = 1'b1;
    load = '0;
    timedOut = 1'b0;
    buildProgram();
    loadProgram();
    @(negedge clk);
    reportTest("reset and program load", 0);
    runTest("immediate and register arithmetic", arithmeticLast);
    runTest("operand forwarding", forwardingLast);
    runTest("store and load round trip", memoryLast);
    runTest("x0 writes and reads", zeroRegisterLast);
    runTest("retire order and timing", timingLast);
    $display("%0d tests passed, %0d tests failed, %0d failing checks",
             testsPassed, testsFailed, failCount);
    if (testsFailed == 0 && !timedOut) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: files.f
+incdir+testbench
design/cpuPkg.sv
design/InstructionFetch.sv
design/RegisterFile.sv
design/Decode.sv
design/PipelineBarrier.sv
design/ForwardingUnit.sv
design/Execute.sv
design/DataMemory.sv
design/CPU.sv
testbench/CPUTb.sv

// File: Bender.yml
package:
  name: rv32i_pipeline

sources:
  - design/cpuPkg.sv
  - design/InstructionFetch.sv
  - design/RegisterFile.sv
  - design/Decode.sv
  - design/PipelineBarrier.sv
  - design/ForwardingUnit.sv
  - design/Execute.sv
  - design/DataMemory.sv
  - design/CPU.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/CPUTb.sv
